// ==== Makefile ====
# Verilator flow for the blitter. Override any variable on the command line.
VERILATOR ?= verilator
TB_TOP    ?= blitterTb
RTL_TOP   ?= blitter
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+include
src/blitterPkg.sv
src/blitterRegs.sv
src/blitterSequencer.sv
src/skewBuffer.sv
src/blitterCore.sv
src/blitter.sv
verification/blitterTb.sv

// ==== include/blitter_config.svh ====
/*
 Blitter sizes and CPU register word indices.
 Word indices 0 to 15 select the halftone RAM, 31 reads as zero.
*/
`ifndef BLITTER_CONFIG_SVH
`define BLITTER_CONFIG_SVH

`define BLT_ADDR_W      23   // Word address, byte address bits 23:1
`define BLT_DATA_W      16
`define BLT_HT_WORDS    16   // Halftone RAM depth

// Register word indices
`define BLT_REG_SRCXINC 16
`define BLT_REG_SRCYINC 17
`define BLT_REG_SRCHI   18
`define BLT_REG_SRCLO   19
`define BLT_REG_LMASK   20
`define BLT_REG_CMASK   21
`define BLT_REG_RMASK   22
`define BLT_REG_DSTXINC 23
`define BLT_REG_DSTYINC 24
`define BLT_REG_DSTHI   25
`define BLT_REG_DSTLO   26
`define BLT_REG_XCOUNT  27
`define BLT_REG_YCOUNT  28
`define BLT_REG_HOPOP   29
`define BLT_REG_CTRL    30

`endif

// ==== src/blitter.sv ====
/*
 Blitter top level. CPU register port plus a single memory master.
 Memory acknowledges with a one-cycle memAck and read data alongside.
*/
`default_nettype none

module blitter (
	input  wire logic                   Clks,
	input  wire logic                   arstN,
	input  wire logic                   cpuWe,
	input  wire logic [4:0]             cpuAddr,
	input  blitterPkg::word_t           cpuWrData,
	output blitterPkg::word_t           cpuRdData,
	output logic                        memReq,
	output blitterPkg::addr_t           memAddr,
	output logic                        memWe,
	output blitterPkg::word_t           memWrData,
	input  wire logic                   memAck,
	input  blitterPkg::word_t           memRdData,
	output logic                        busy
);

	blitterPkg::bltCfg_s cfg;
	blitterPkg::regLoad_s load;
	blitterPkg::seqStatus_s status;
	blitterPkg::seqStep_s step;
	blitterPkg::word_t htRdData, srcWord, wrData;
	logic htWe, needSrc, needDest;

	assign busy = status.busy;

	blitterRegs uRegs (.Clks, .arstN, .cpuWe, .cpuAddr, .cpuWrData, .status, .htRdData,
		.cfg, .load, .htWe, .cpuRdData);

	blitterSequencer uSeq (.Clks, .arstN, .cfg, .load, .needSrc, .needDest, .wrData, .memAck,
		.status, .step, .memReq, .memAddr, .memWe, .memWrData);

	skewBuffer uSkew (.Clks, .arstN, .cfg, .step, .memRdData, .srcWord);

	blitterCore uCore (.Clks, .arstN, .cfg, .step, .srcWord, .memRdData, .htWe,
		.htAddr(cpuAddr[3:0]), .htWrData(cpuWrData), .htRdData, .needSrc, .needDest, .wrData);

endmodule

`default_nettype wire

// ==== src/blitterCore.sv ====
/*
 Logic-op core. Halftone RAM with combinational reads, destination latch,
 HOP and OP functions, end mask and the read-need decisions.
*/
`default_nettype none

`include "blitter_config.svh"

module blitterCore (
	input  wire logic                   Clks,
	input  wire logic                   arstN,
	input  blitterPkg::bltCfg_s         cfg,
	input  blitterPkg::seqStep_s        step,
	input  blitterPkg::word_t           srcWord,
	input  blitterPkg::word_t           memRdData,
	input  wire logic                   htWe,
	input  wire logic [3:0]             htAddr,
	input  blitterPkg::word_t           htWrData,
	output blitterPkg::word_t           htRdData,
	output logic                        needSrc,
	output logic                        needDest,
	output blitterPkg::word_t           wrData
);

	blitterPkg::word_t htRam [`BLT_HT_WORDS];
	blitterPkg::word_t destWord, htWord, hopWord, mask;
	logic opNoSrc, opUsesDest;

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `BLT_HT_WORDS; i++)
				htRam[i] <= '0;
		end else if (htWe)
			htRam[htAddr] <= htWrData;
	end

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN)
			destWord <= '0;
		else if (step.destLatch)
			destWord <= memRdData;
	end

	assign htRdData = htRam[htAddr];
	assign htWord = htRam[step.line];

	always_comb begin
		case (cfg.hopOp.hop)
			2'd0:    hopWord = '1;
			2'd1:    hopWord = htWord;
			2'd2:    hopWord = srcWord;
			default: hopWord = srcWord & htWord;
		endcase
	end

	always_comb begin
		case (step.maskSel)
			blitterPkg::maskLeft:  mask = cfg.lMask;
			blitterPkg::maskRight: mask = cfg.rMask;
			default:               mask = cfg.cMask;
		endcase
	end

	// OP bit index is 3 - 2S - D, the inverse of {S, D}
	always_comb begin
		logic [1:0] opIdx;
		for (int i = 0; i < $bits(blitterPkg::word_t); i++) begin
			opIdx = {~hopWord[i], ~destWord[i]};
			wrData[i] = mask[i] ? cfg.hopOp.op[opIdx] : destWord[i];   // Masked bits keep dest
		end
	end

	// OP 0, 5, 10 and 15 ignore the source
	assign opNoSrc = (cfg.hopOp.op[3] == cfg.hopOp.op[1]) & (cfg.hopOp.op[2] == cfg.hopOp.op[0]);
	assign opUsesDest = (cfg.hopOp.op[3] ^ cfg.hopOp.op[2]) | (cfg.hopOp.op[1] ^ cfg.hopOp.op[0]);
	assign needSrc = cfg.hopOp.hop[1] & ~opNoSrc;
	assign needDest = opUsesDest | ~&mask;

endmodule

`default_nettype wire

// ==== src/blitterPkg.sv ====
/*
 Shared blitter types. Field layouts follow the CPU register words.
 Increments hold data bits 15:1, bit 0 is always zero.
*/
`default_nettype none

`include "blitter_config.svh"

package blitterPkg;

	typedef logic [`BLT_DATA_W-1:0] word_t;
	typedef logic [`BLT_ADDR_W-1:0] addr_t;
	typedef logic signed [14:0] incr_t;        // Signed word increment

	typedef enum logic [1:0] {maskLeft, maskCenter, maskRight} maskSel_e;

	typedef struct packed {
		logic [5:0] rsvHi;
		logic [1:0] hop;                        // Bits 9:8
		logic [3:0] rsvLo;
		logic [3:0] op;                         // Bits 3:0
	} hopOp_s;

	typedef struct packed {
		logic busy;                             // Bit 15
		logic [2:0] rsvHi;
		logic [3:0] line;                       // Halftone line index
		logic fxsr;                             // Extra source read per line
		logic [2:0] rsvLo;
		logic [3:0] skew;
	} ctrl_s;

	// One CPU word, decoded by register index
	typedef union packed {
		word_t raw;
		hopOp_s hopOp;
		ctrl_s ctrl;
	} regWord_u;

	typedef struct packed {
		incr_t srcXInc;
		incr_t srcYInc;
		incr_t dstXInc;
		incr_t dstYInc;
		word_t lMask;
		word_t cMask;
		word_t rMask;
		hopOp_s hopOp;
		logic fxsr;
		logic [3:0] skew;
	} bltCfg_s;

	typedef struct packed {
		logic srcHi, srcLo, dstHi, dstLo;       // Address word loads
		logic xCount, yCount, line;
		logic start, stop;
		word_t data;                            // Written CPU word
	} regLoad_s;

	typedef struct packed {
		addr_t srcAddr;
		addr_t dstAddr;
		word_t xCount;
		word_t yCount;
		logic [3:0] line;
		logic busy;
	} seqStatus_s;

	typedef struct packed {
		logic srcLatch;                         // Source word on memRdData
		logic destLatch;                        // Destination word on memRdData
		maskSel_e maskSel;
		logic [3:0] line;
	} seqStep_s;

endpackage

`default_nettype wire

// ==== src/blitterRegs.sv ====
/*
 CPU register file. Only the control word is writable while busy.
 Address, count and LINE writes go to the sequencer as load strobes.
 Read-back is combinational from cpuAddr.
*/
`default_nettype none

`include "blitter_config.svh"

module blitterRegs (
	input  wire logic                   Clks,
	input  wire logic                   arstN,
	input  wire logic                   cpuWe,
	input  wire logic [4:0]             cpuAddr,
	input  blitterPkg::regWord_u        cpuWrData,
	input  blitterPkg::seqStatus_s      status,
	input  blitterPkg::word_t           htRdData,
	output blitterPkg::bltCfg_s         cfg,
	output blitterPkg::regLoad_s        load,
	output logic                        htWe,
	output blitterPkg::word_t           cpuRdData
);

	logic wrOpen;          // Any register may take the write
	logic ctrlWr;
	logic countsValid;
	blitterPkg::ctrl_s ctrlRd;

	assign wrOpen = cpuWe & ~status.busy;
	assign ctrlWr = cpuWe & (cpuAddr == `BLT_REG_CTRL);
	assign countsValid = (status.xCount != '0) & (status.yCount != '0);
	assign htWe = wrOpen & ~cpuAddr[4];   // Low half of the map is halftone

	// Strobes to the sequencer, taken on the next edge
	always_comb begin
		load = '0;
		load.data = cpuWrData.raw;
		load.srcHi = wrOpen & (cpuAddr == `BLT_REG_SRCHI);
		load.srcLo = wrOpen & (cpuAddr == `BLT_REG_SRCLO);
		load.dstHi = wrOpen & (cpuAddr == `BLT_REG_DSTHI);
		load.dstLo = wrOpen & (cpuAddr == `BLT_REG_DSTLO);
		load.xCount = wrOpen & (cpuAddr == `BLT_REG_XCOUNT);
		load.yCount = wrOpen & (cpuAddr == `BLT_REG_YCOUNT);
		load.line = ctrlWr & ~status.busy;
		load.start = load.line & cpuWrData.ctrl.busy & countsValid;
		load.stop = ctrlWr & status.busy & ~cpuWrData.ctrl.busy;   // Abort request
	end

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN) begin
			cfg <= '0;
		end else if (wrOpen) begin
			case (cpuAddr)
				`BLT_REG_SRCXINC: cfg.srcXInc <= cpuWrData.raw[15:1];
				`BLT_REG_SRCYINC: cfg.srcYInc <= cpuWrData.raw[15:1];
				`BLT_REG_DSTXINC: cfg.dstXInc <= cpuWrData.raw[15:1];
				`BLT_REG_DSTYINC: cfg.dstYInc <= cpuWrData.raw[15:1];
				`BLT_REG_LMASK:   cfg.lMask <= cpuWrData.raw;
				`BLT_REG_CMASK:   cfg.cMask <= cpuWrData.raw;
				`BLT_REG_RMASK:   cfg.rMask <= cpuWrData.raw;
				`BLT_REG_HOPOP: begin
					cfg.hopOp.hop <= cpuWrData.hopOp.hop;   // Reserved bits stay zero
					cfg.hopOp.op <= cpuWrData.hopOp.op;
				end
				`BLT_REG_CTRL: begin
					cfg.fxsr <= cpuWrData.ctrl.fxsr;
					cfg.skew <= cpuWrData.ctrl.skew;
				end
				default: ;
			endcase
		end
	end

	// Control word as the CPU sees it
	always_comb begin
		ctrlRd = '0;
		ctrlRd.busy = status.busy;
		ctrlRd.line = status.line;
		ctrlRd.fxsr = cfg.fxsr;
		ctrlRd.skew = cfg.skew;
	end

	always_comb begin
		case (cpuAddr)
			`BLT_REG_SRCXINC: cpuRdData = {cfg.srcXInc, 1'b0};
			`BLT_REG_SRCYINC: cpuRdData = {cfg.srcYInc, 1'b0};
			`BLT_REG_SRCHI:   cpuRdData = {8'h00, status.srcAddr[`BLT_ADDR_W-1 -: 8]};
			`BLT_REG_SRCLO:   cpuRdData = {status.srcAddr[14:0], 1'b0};
			`BLT_REG_LMASK:   cpuRdData = cfg.lMask;
			`BLT_REG_CMASK:   cpuRdData = cfg.cMask;
			`BLT_REG_RMASK:   cpuRdData = cfg.rMask;
			`BLT_REG_DSTXINC: cpuRdData = {cfg.dstXInc, 1'b0};
			`BLT_REG_DSTYINC: cpuRdData = {cfg.dstYInc, 1'b0};
			`BLT_REG_DSTHI:   cpuRdData = {8'h00, status.dstAddr[`BLT_ADDR_W-1 -: 8]};
			`BLT_REG_DSTLO:   cpuRdData = {status.dstAddr[14:0], 1'b0};
			`BLT_REG_XCOUNT:  cpuRdData = status.xCount;
			`BLT_REG_YCOUNT:  cpuRdData = status.yCount;
			`BLT_REG_HOPOP:   cpuRdData = cfg.hopOp;
			`BLT_REG_CTRL:    cpuRdData = ctrlRd;
			default:          cpuRdData = cpuAddr[4] ? '0 : htRdData;   // Index 31 is empty
		endcase
	end

endmodule

`default_nettype wire

// ==== src/blitterSequencer.sv ====
/*
 Blit sequencer. One memory cycle in flight, memReq drops for at least
 one cycle after each acknowledge. A stop ends the blit once the
 current memory cycle completes. Loads only arrive while idle.
*/
`default_nettype none

`include "blitter_config.svh"

module blitterSequencer (
	input  wire logic                   Clks,
	input  wire logic                   arstN,
	input  blitterPkg::bltCfg_s         cfg,
	input  blitterPkg::regLoad_s        load,
	input  wire logic                   needSrc,
	input  wire logic                   needDest,
	input  blitterPkg::word_t           wrData,
	input  wire logic                   memAck,
	output blitterPkg::seqStatus_s      status,
	output blitterPkg::seqStep_s        step,
	output logic                        memReq,
	output blitterPkg::addr_t           memAddr,
	output logic                        memWe,
	output blitterPkg::word_t           memWrData
);

	typedef enum logic [2:0] {stIdle, stXSrc, stSrc, stDst, stWr} state_e;

	state_e state, firstState, nextState;
	blitterPkg::addr_t srcAddr, dstAddr;
	blitterPkg::word_t xCount, yCount, xStart;
	blitterPkg::ctrl_s loadCtrl;          // Written word seen as the control word
	logic [3:0] line;
	logic busy, stopReq, firstWord;
	logic acked, srcStep, wrDone, xLast, stopNow;

	// Signed increment to address width
	function automatic blitterPkg::addr_t extInc(input blitterPkg::incr_t inc);
		return {{(`BLT_ADDR_W-15){inc[14]}}, inc};
	endfunction

	assign loadCtrl = load.data;
	assign acked = memReq & memAck;
	assign srcStep = acked & ((state == stXSrc) | (state == stSrc));
	assign wrDone = acked & (state == stWr);
	assign xLast = (xCount == 1);
	assign stopNow = load.stop | stopReq;

	// First memory cycle of the next word
	always_comb begin
		if (needSrc)       firstState = (cfg.fxsr & firstWord) ? stXSrc : stSrc;
		else if (needDest) firstState = stDst;
		else               firstState = stWr;
	end

	always_comb begin
		case (state)
			stXSrc:  nextState = stSrc;
			stSrc:   nextState = needDest ? stDst : stWr;
			stDst:   nextState = stWr;
			default: nextState = stIdle;   // Back to idle to pick the next word
		endcase
	end

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			{busy, stopReq, memReq, firstWord} <= '0;
			{srcAddr, dstAddr} <= '0;
			{xCount, yCount, xStart} <= '0;
			line <= '0;
		end else begin
			if (load.srcHi) srcAddr[`BLT_ADDR_W-1 -: 8] <= load.data[7:0];
			if (load.srcLo) srcAddr[14:0] <= load.data[15:1];
			if (load.dstHi) dstAddr[`BLT_ADDR_W-1 -: 8] <= load.data[7:0];
			if (load.dstLo) dstAddr[14:0] <= load.data[15:1];
			if (load.xCount) begin
				xCount <= load.data;
				xStart <= load.data;          // Reload value per line
			end
			if (load.yCount) yCount <= load.data;
			if (load.line) line <= loadCtrl.line;
			if (load.start) begin
				busy <= 1'b1;
				firstWord <= 1'b1;
			end

			case (state)
				stIdle: if (busy) begin
					if (stopNow) begin
						busy <= 1'b0;
						stopReq <= 1'b0;
					end else
						state <= firstState;
				end
				default: begin
					if (!memReq) begin
						if (stopNow) begin          // Cycle not started yet
							busy <= 1'b0;
							stopReq <= 1'b0;
							state <= stIdle;
						end else
							memReq <= 1'b1;
					end else if (memAck) begin
						memReq <= 1'b0;
						state <= nextState;
						if (stopNow | (wrDone & xLast & (yCount == 1))) begin
							busy <= 1'b0;           // Blit done or aborted
							stopReq <= 1'b0;
							state <= stIdle;
						end
					end else if (load.stop)
						stopReq <= 1'b1;            // Wait for the acknowledge
				end
			endcase

			// Y increment on the last source read of a line
			if (srcStep)
				srcAddr <= srcAddr + extInc(((state == stSrc) & xLast) ? cfg.srcYInc : cfg.srcXInc);

			if (wrDone) begin
				dstAddr <= dstAddr + extInc(xLast ? cfg.dstYInc : cfg.dstXInc);
				firstWord <= xLast;
				if (xLast) begin
					xCount <= xStart;
					yCount <= yCount - 1'b1;
					line <= (cfg.dstYInc < 0) ? line - 1'b1 : line + 1'b1;
				end else
					xCount <= xCount - 1'b1;
			end
		end
	end

	assign memAddr = ((state == stXSrc) | (state == stSrc)) ? srcAddr : dstAddr;
	assign memWe = (state == stWr);
	assign memWrData = wrData;           // Stable while in the write state

	always_comb begin
		step.srcLatch = srcStep;
		step.destLatch = acked & (state == stDst);
		step.line = line;
		if (firstWord)  step.maskSel = blitterPkg::maskLeft;   // Left wins on one-word lines
		else if (xLast) step.maskSel = blitterPkg::maskRight;
		else            step.maskSel = blitterPkg::maskCenter;
	end

	assign status = '{srcAddr: srcAddr, dstAddr: dstAddr, xCount: xCount,
		yCount: yCount, line: line, busy: busy};

endmodule

`default_nettype wire

// ==== src/skewBuffer.sv ====
/*
 Source skew buffer. Two source words, direction from the sign of the
 source X increment. Output is the low word after the skew shift.
*/
`default_nettype none

module skewBuffer (
	input  wire logic                   Clks,
	input  wire logic                   arstN,
	input  blitterPkg::bltCfg_s         cfg,
	input  blitterPkg::seqStep_s        step,
	input  blitterPkg::word_t           memRdData,
	output blitterPkg::word_t           srcWord
);

	logic [31:0] shiftReg;
	logic [31:0] skewed;

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN)
			shiftReg <= '0;
		else if (step.srcLatch) begin
			if (cfg.srcXInc < 0)
				shiftReg <= {memRdData, shiftReg[31:16]};   // Right to left, new word on top
			else
				shiftReg <= {shiftReg[15:0], memRdData};    // Left to right
		end
	end

	assign skewed = shiftReg >> cfg.skew;
	assign srcWord = skewed[15:0];

endmodule

`default_nettype wire

// ==== verification/blitterTb.sv ====
/*
 Blitter testbench. 4096-word memory, addresses wrap at 12 bits,
 0 to 3 wait cycles per access. A software model predicts each blit.
*/
`default_nettype none

`include "blitter_config.svh"

module blitterTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int memCycles = 636;                 // Copy 24, XOR 48, halftone 16, skew 36, stop 512
	localparam int cycleLimit = 4 * memCycles * 6;

	logic Clks, arstN, cpuWe, memReq, memWe, busy;
	logic memAck = 1'b0;
	logic [4:0] cpuAddr;
	blitterPkg::word_t cpuWrData, cpuRdData, memWrData;
	blitterPkg::word_t memRdData = '0;
	blitterPkg::addr_t memAddr;

	blitterPkg::word_t mem [4096];
	blitterPkg::word_t expMem [4096];
	blitterPkg::word_t htModel [16];
	logic allowed [4096];                            // Destination words of the current blit
	logic [31:0] waitRng = 32'hf15e;
	logic [31:0] dataRng, modelSr;
	int errors, memErrors = 0, cycles = 0, waitCnt = 0, reads = 0, writes = 0, expReads;
	logic ackDone = 1'b0, reqPend = 1'b0, prevReq = 1'b0, stopArmed = 1'b0;
	blitterPkg::addr_t modelSrc, modelDst;
	logic [3:0] modelLine;

	blitter DUT (.Clks, .arstN, .cpuWe, .cpuAddr, .cpuWrData, .cpuRdData, .memReq, .memAddr,
		.memWe, .memWrData, .memAck, .memRdData, .busy);

	initial begin
		Clks = 1'b0;
		forever #50 Clks = ~Clks;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	// Memory model and protocol monitor, all driven on the falling edge
	always @(negedge Clks) begin : memModel
		logic [11:0] a;
		a = memAddr[11:0];
		if (!arstN)
			for (int i = 0; i < 4096; i++)
				mem[i] = blitterPkg::word_t'(i * 32'h9e37) ^ 16'(i << 4);   // Whole-address fill
		if (reqPend && !memReq) begin
			memErrors++;
			$display("memReq dropped before its acknowledge at %0t", $time);
		end
		if (memReq && !prevReq && stopArmed) begin
			memErrors++;
			$display("New memory cycle started after the stop write at %0t", $time);
		end
		memAck = 1'b0;
		if (!memReq)
			ackDone = 1'b0;
		else if (!ackDone) begin
			if (waitCnt > 0)
				waitCnt--;
			else begin
				memAck = 1'b1;
				ackDone = 1'b1;
				memRdData = mem[a];
				if (memWe) begin
					if (!allowed[a]) begin
						memErrors++;
						$display("Write to word %h outside the destination at %0t", a, $time);
					end
					mem[a] = memWrData;
					writes++;
				end else
					reads++;
				waitRng = xorshift(waitRng);
				waitCnt = int'(waitRng[1:0]);       // 0 to 3 wait cycles
			end
		end
		reqPend = memReq && !ackDone;
		prevReq = memReq;
	end

	// Arms on a control write with busy clear during a blit, disarms on the next start
	always @(posedge Clks)
		if (cpuWe && cpuAddr == 5'(`BLT_REG_CTRL))
			stopArmed <= !cpuWrData[15] && busy;

	always @(posedge Clks) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout, run exceeded %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic checkWord(input string name, input blitterPkg::word_t got, exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input blitterPkg::addr_t got, exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic writeReg(input int idx, input blitterPkg::word_t data);
		@(negedge Clks);
		cpuWe = 1'b1;
		cpuAddr = 5'(idx);
		cpuWrData = data;
		@(negedge Clks);
		cpuWe = 1'b0;
	endtask

	task automatic readReg(input int idx, output blitterPkg::word_t data);
		@(negedge Clks);
		cpuAddr = 5'(idx);
		@(negedge Clks);
		data = cpuRdData;
	endtask

	// Bits that read back in each register's layout
	function automatic blitterPkg::word_t readMask(input int idx);
		case (idx)
			`BLT_REG_SRCXINC, `BLT_REG_SRCYINC, `BLT_REG_DSTXINC, `BLT_REG_DSTYINC,
			`BLT_REG_SRCLO, `BLT_REG_DSTLO: return 16'hfffe;
			`BLT_REG_SRCHI, `BLT_REG_DSTHI: return 16'h00ff;
			`BLT_REG_HOPOP: return 16'h030f;
			`BLT_REG_CTRL:  return 16'h0f8f;
			default:        return 16'hffff;
		endcase
	endfunction

	task automatic regTest;
		blitterPkg::word_t v, w;
		for (int i = 0; i < 32; i++) begin
			readReg(i, v);
			checkWord($sformatf("reg %0d after reset", i), v, '0);
		end
		for (int i = 0; i < 31; i++) begin
			dataRng = xorshift(dataRng);
			w = dataRng[15:0];
			if (i == `BLT_REG_CTRL)
				w[15] = 1'b0;                       // Busy bit clear, no blit starts
			writeReg(i, w);
			readReg(i, v);
			checkWord($sformatf("reg %0d", i), v, w & readMask(i));
			if (i < 16)
				htModel[i] = w;
		end
	endtask

	// Pushes one source word into the model skew register
	task automatic shiftSrc(input int sxi);
		blitterPkg::word_t w;
		w = expMem[modelSrc[11:0]];
		modelSr = (sxi < 0) ? {w, modelSr[31:16]} : {modelSr[15:0], w};
		expReads++;
	endtask

	task automatic modelBlit(input logic [1:0] hop, input logic [3:0] op, skew, input logic fxsr,
		input int sxi, syi, dxi, dyi, xc, yc, input blitterPkg::word_t lm, cm, rm);
		blitterPkg::word_t mask, s, d, h, res;
		logic [31:0] sh;
		logic [1:0] k;
		logic needS, needD, first;
		for (int i = 0; i < 4096; i++) begin
			expMem[i] = mem[i];
			allowed[i] = 1'b0;
		end
		expReads = 0;
		needS = hop[1] && !(op[3] == op[1] && op[2] == op[0]);
		for (int y = yc; y > 0; y--) begin
			for (int x = xc; x > 0; x--) begin
				first = (x == xc);
				mask = first ? lm : ((x == 1) ? rm : cm);   // Left end has priority
				needD = (op[3] ^ op[2]) | (op[1] ^ op[0]) | (mask != 16'hffff);
				if (needS && fxsr && first) begin
					shiftSrc(sxi);
					modelSrc = modelSrc + blitterPkg::addr_t'(sxi);
				end
				if (needS) begin
					shiftSrc(sxi);
					modelSrc = modelSrc + blitterPkg::addr_t'((x == 1) ? syi : sxi);
				end
				d = needD ? expMem[modelDst[11:0]] : '0;
				if (needD)
					expReads++;
				sh = modelSr >> skew;
				s = sh[15:0];
				case (hop)
					2'd0: h = '1;
					2'd1: h = htModel[modelLine];
					2'd2: h = s;
					default: h = s & htModel[modelLine];
				endcase
				for (int b = 0; b < 16; b++) begin
					k = 2'd3 - {h[b], 1'b0} - {1'b0, d[b]};
					res[b] = mask[b] ? op[k] : d[b];
				end
				expMem[modelDst[11:0]] = res;
				allowed[modelDst[11:0]] = 1'b1;
				modelDst = modelDst + blitterPkg::addr_t'((x == 1) ? dyi : dxi);
			end
			modelLine = (dyi < 0) ? modelLine - 4'd1 : modelLine + 4'd1;
		end
	endtask

	task automatic runBlit(input logic [1:0] hop, input logic [3:0] op, skew, input logic fxsr,
		input logic [3:0] line, input int src, dst, sxi, syi, dxi, dyi, xc, yc,
		input blitterPkg::word_t lm, cm, rm, input logic stopEarly);
		blitterPkg::addr_t sa, da;
		blitterPkg::word_t hi, lo, ctrl;
		int r0, w0;
		sa = blitterPkg::addr_t'(src);
		da = blitterPkg::addr_t'(dst);
		ctrl = {4'b0, line, fxsr, 3'b0, skew};
		writeReg(`BLT_REG_SRCXINC, 16'(sxi * 2));
		writeReg(`BLT_REG_SRCYINC, 16'(syi * 2));
		writeReg(`BLT_REG_DSTXINC, 16'(dxi * 2));
		writeReg(`BLT_REG_DSTYINC, 16'(dyi * 2));
		writeReg(`BLT_REG_SRCHI, {8'h00, sa[22:15]});
		writeReg(`BLT_REG_SRCLO, {sa[14:0], 1'b0});
		writeReg(`BLT_REG_DSTHI, {8'h00, da[22:15]});
		writeReg(`BLT_REG_DSTLO, {da[14:0], 1'b0});
		writeReg(`BLT_REG_LMASK, lm);
		writeReg(`BLT_REG_CMASK, cm);
		writeReg(`BLT_REG_RMASK, rm);
		writeReg(`BLT_REG_XCOUNT, 16'(xc));
		writeReg(`BLT_REG_YCOUNT, 16'(yc));
		writeReg(`BLT_REG_HOPOP, {6'b0, hop, 4'b0, op});
		modelSrc = sa;
		modelDst = da;
		modelLine = line;
		modelBlit(hop, op, skew, fxsr, sxi, syi, dxi, dyi, xc, yc, lm, cm, rm);
		r0 = reads;
		w0 = writes;
		writeReg(`BLT_REG_CTRL, ctrl | 16'h8000);
		if (!busy) begin
			errors++;
			$display("busy did not rise after the start write");
		end
		if (stopEarly) begin
			repeat (40) @(negedge Clks);
			writeReg(`BLT_REG_CTRL, ctrl);
		end
		while (busy)
			@(negedge Clks);
		if (stopEarly) begin
			if (writes - w0 == 0 || writes - w0 >= xc * yc) begin
				errors++;
				$display("Stop did not cut the blit short, %0d words written", writes - w0);
			end
		end else begin
			for (int i = 0; i < 4096; i++)
				checkWord($sformatf("mem[%h]", i), mem[i], expMem[i]);
			checkWord("readCount", 16'(reads - r0), 16'(expReads));
			readReg(`BLT_REG_SRCHI, hi);
			readReg(`BLT_REG_SRCLO, lo);
			checkAddr("srcAddr", {hi[7:0], lo[15:1]}, modelSrc);
			readReg(`BLT_REG_DSTHI, hi);
			readReg(`BLT_REG_DSTLO, lo);
			checkAddr("dstAddr", {hi[7:0], lo[15:1]}, modelDst);
			readReg(`BLT_REG_CTRL, hi);
			checkWord("ctrl", hi, {4'b0, modelLine, fxsr, 3'b0, skew});
		end
	endtask

	initial begin
		cpuWe = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		arstN = 1'b0;
		errors = 0;
		dataRng = 32'hf15e;
		modelSr = '0;
		repeat (4) @(posedge Clks);
		@(negedge Clks);
		arstN = 1'b1;
		regTest;
		runBlit(2'd2, 4'd3, 4'd0, 1'b0, 4'd0, 100, 1000, 1, 13, 1, 13, 4, 3,
			'1, '1, '1, 1'b0);                       // Copy
		runBlit(2'd2, 4'd6, 4'd0, 1'b0, 4'd0, 200, 1200, 1, 8, 1, 8, 1, 2,
			16'hff0f, 16'h3c3c, 16'hf00f, 1'b0);     // XOR, one-word lines
		runBlit(2'd2, 4'd6, 4'd0, 1'b0, 4'd0, 240, 1240, 1, 7, 1, 7, 2, 2,
			16'hff0f, 16'h3c3c, 16'hf00f, 1'b0);
		runBlit(2'd2, 4'd6, 4'd0, 1'b0, 4'd0, 280, 1280, 1, 4, 1, 4, 5, 2,
			16'hff0f, 16'h3c3c, 16'hf00f, 1'b0);
		runBlit(2'd1, 4'd3, 4'd0, 1'b0, 4'd2, 0, 2100, 1, 0, 1, -19, 4, 4,
			'1, '1, '1, 1'b0);                       // Halftone, LINE counts down
		runBlit(2'd2, 4'd3, 4'd5, 1'b1, 4'd0, 300, 3000, 1, 12, 1, 13, 4, 2,
			'1, '1, '1, 1'b0);                       // Skew, left to right
		runBlit(2'd2, 4'd3, 4'd5, 1'b1, 4'd0, 520, 3103, -1, 20, -1, 19, 4, 2,
			'1, '1, '1, 1'b0);                       // Skew, right to left
		runBlit(2'd2, 4'd3, 4'd0, 1'b0, 4'd0, 0, 3500, 1, 1, 1, 1, 16, 16,
			'1, '1, '1, 1'b1);                       // Stopped copy
		$display("Errors: %0d", errors + memErrors);
		if (errors + memErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
